// File: all.f
+incdir+testbench
src/nn_fixed_pkg.sv
src/eval_pkg.sv
src/fx_multiply.sv
src/cost_unit.sv
src/class_unit.sv
src/eval_accum.sv
src/output_eval_top.sv
testbench/output_eval_tb.sv

// File: Bender.yml
package:
  name: output_eval

sources:
  # packages first, the modules use them by scoped name
  - src/nn_fixed_pkg.sv
  - src/eval_pkg.sv
  - src/fx_multiply.sv
  - src/cost_unit.sv
  - src/class_unit.sv
  - src/eval_accum.sv
  - src/output_eval_top.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/output_eval_tb.sv

// File: testbench/eval_model.svh
// integer reference model for the 1.5.10 format; the rounding and clamping rules are re-derived here
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

// clamp any integer into the signed fixed-point range
function automatic int clamp_fixed(input longint v);
	longint hi;
	longint lo;

	hi = (longint'(1) <<< (nn_fixed_pkg::fixed_width - 1)) - 1; // +32767 raw
	lo = -(longint'(1) <<< (nn_fixed_pkg::fixed_width - 1)); // -32768 raw
	if (v > hi) begin
		return int'(hi);
	end
	if (v < lo) begin
		return int'(lo);
	end
	return int'(v);
endfunction

// floor division for a positive divisor, since / truncates toward zero
function automatic longint floor_div(input longint n, input longint d);
	longint q;

	q = n / d;
	if ((n % d != 0) && (n < 0)) begin
		q = q - 1; // negative quotient with a remainder, step down once
	end
	return q;
endfunction

// exact product scaled by 1/1024, half rounds toward +inf, then clamped
function automatic int round_product(input int a, input int b);
	longint one;
	longint p;

	one = longint'(1) <<< nn_fixed_pkg::frac_bits;
	p   = longint'(a) * longint'(b); // exact, 20 fraction bits
	return clamp_fixed(floor_div(p + one / 2, one));
endfunction

// activation i of a sample as a plain signed integer
function automatic int act_value(input eval_pkg::sample_t s, input int i);
	return int'($signed(s.acts[i]));
endfunction

// quadratic cost of one sample, every intermediate step clamped
function automatic int sample_cost(input eval_pkg::sample_t s);
	int y;
	int d;
	int sq;
	int sum;

	sum = 0;
	for (int i = 0; i < eval_pkg::num_neurons; i++) begin
		y   = (int'(s.label) == i) ? (1 << nn_fixed_pkg::frac_bits) : 0; // one-hot target
		d   = clamp_fixed(longint'(act_value(s, i)) - y); // a-y, may hit fixed_min
		sq  = round_product(d, d);
		sum = clamp_fixed(longint'(sum) + sq); // index order matters once it clamps
	end
	return sum;
endfunction

// position of the largest activation; a strict compare keeps the lowest index on ties
function automatic int argmax_low(input eval_pkg::sample_t s);
	int best;

	best = 0;
	for (int i = 1; i < eval_pkg::num_neurons; i++) begin
		if (act_value(s, i) > act_value(s, best)) begin
			best = i;
		end
	end
	return best;
endfunction

// prediction matches the label
function automatic logic prediction_correct(input eval_pkg::sample_t s);
	return (argmax_low(s) == int'(s.label));
endfunction

`endif

// File: testbench/output_eval_tb.sv
// self-checking testbench for output_eval_top; fixed lcg seed, results checked at the falling edge
`timescale 1ns/1ns

module output_eval_tb;

	localparam int num_directed   = 3;
	localparam int num_random_a   = 207; // run before the second reset, leaves a partial batch
	localparam int num_random_b   = 120;
	localparam int num_total      = num_directed + num_random_a + num_random_b;
	localparam int timeout_cycles = num_total * 20 + 200; // margin covers resets and drain

	// expected per-sample result and the cycle its strobe is due
	typedef struct packed {
		eval_pkg::sample_res_t res;
		logic                  batch_end; // this sample closes a batch
		logic [31:0]           cycle;
	} sample_exp_t;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  sample_valid_i;
	eval_pkg::sample_t     sample_i;
	logic                  sample_done_o;
	eval_pkg::sample_res_t sample_res_o;
	logic                  batch_done_o;
	eval_pkg::batch_res_t  batch_res_o;

	logic [31:0] lcg_state = 32'd83066;
	logic [31:0] cycle_cnt = '0; // rising edges so far
	int          errors = 0;
	int          checks = 0;

	sample_exp_t          sample_exp_q [$];
	eval_pkg::batch_res_t batch_exp_q [$];

	// batch model state
	int batch_pos;
	int batch_cost;
	int batch_cnt;

	`include "eval_model.svh"

	output_eval_top dut0 (
		.clk            (clk),
		.reset          (reset),
		.sample_valid_i (sample_valid_i),
		.sample_i       (sample_i),
		.sample_done_o  (sample_done_o),
		.sample_res_o   (sample_res_o),
		.batch_done_o   (batch_done_o),
		.batch_res_o    (batch_res_o)
	);

	always #5 clk = ~clk; // 10 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {8'd0, lcg_state[31:8]}; // low bits of an lcg cycle too fast
	endfunction

	function automatic int rand_range(input int n);
		return int'(lcg_rand() % n);
	endfunction

	// one activation of a given magnitude class
	function automatic nn_fixed_pkg::fixed_t random_act(input int kind);
		int v;
		int mag;
		int one;

		one = 1 << nn_fixed_pkg::frac_bits;
		case (kind)
			0, 1, 2: v = rand_range(2 * one - 1) - (one - 1); // |a| < 1.0
			3, 4: v = ((rand_range(2) != 0) ? one : -one) + rand_range(65) - 32; // near +-1
			5, 6: v = rand_range(16383) - 8191; // up to +-8, square may clamp
			7: begin
				mag = 8192 + rand_range(24575); // 8..32, square always clamps
				v   = (rand_range(2) != 0) ? mag : -mag;
			end
			8: v = (rand_range(2) != 0) ? 32767 : -32768; // the extremes
			default: v = rand_range(65536) - 32768; // anything
		endcase
		return nn_fixed_pkg::fixed_t'(v);
	endfunction

	function automatic eval_pkg::sample_t random_sample();
		eval_pkg::sample_t s;
		int profile;
		int kind;
		int src;
		int dst;

		profile = rand_range(3); // small only, mixed, or saturation heavy
		for (int i = 0; i < eval_pkg::num_neurons; i++) begin
			case (profile)
				0: kind = rand_range(5);
				1: kind = rand_range(10);
				default: kind = 5 + rand_range(5);
			endcase
			s.acts[i] = random_act(kind);
		end
		if (rand_range(4) == 0) begin
			src         = rand_range(eval_pkg::num_neurons);
			dst         = rand_range(eval_pkg::num_neurons);
			s.acts[dst] = s.acts[src]; // forced tie
		end
		// half the labels hit the argmax so the correct count moves
		if (rand_range(2) == 0) begin
			s.label = eval_pkg::class_t'(argmax_low(s));
		end else begin
			s.label = eval_pkg::class_t'(rand_range(eval_pkg::num_neurons));
		end
		return s;
	endfunction

	function automatic eval_pkg::sample_t uniform_sample(input nn_fixed_pkg::fixed_t v,
		input eval_pkg::class_t label);
		eval_pkg::sample_t s;

		for (int i = 0; i < eval_pkg::num_neurons; i++) begin
			s.acts[i] = v;
		end
		s.label = label;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// drive one sample and queue what should come back
	task automatic send_sample(input eval_pkg::sample_t s);
		sample_exp_t e;
		int          cost;
		logic        ok;

		@(posedge clk);
		#1;
		sample_valid_i = 1'b1;
		sample_i       = s;
		cost           = sample_cost(s);
		ok             = prediction_correct(s);
		e.res.cost     = nn_fixed_pkg::fixed_t'(cost);
		e.res.correct  = ok;
		e.cycle        = cycle_cnt + 2; // two-cycle latency
		batch_cost = clamp_fixed(longint'(batch_cost) + cost);
		batch_cnt  = batch_cnt + int'(ok);
		batch_pos++;
		e.batch_end = (batch_pos == eval_pkg::batch_len); // eighth sample of its batch
		if (batch_pos == eval_pkg::batch_len) begin
			batch_exp_q.push_back({nn_fixed_pkg::fixed_t'(batch_cost),
				eval_pkg::count_t'(batch_cnt)});
			batch_pos  = 0;
			batch_cost = 0;
			batch_cnt  = 0;
		end
		sample_exp_q.push_back(e);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			sample_valid_i = 1'b0;
		end
	endtask

	task automatic run_random(input int n);
		for (int k = 0; k < n; k++) begin
			send_sample(random_sample());
			if (rand_range(2) != 0) begin
				idle_cycles(rand_range(4)); // 0 keeps it back-to-back
			end
		end
	endtask

	// stop driving and let the pipeline empty
	task automatic wait_drain();
		idle_cycles(1);
		while (sample_exp_q.size() != 0) begin
			@(posedge clk);
		end
		idle_cycles(4); // late or extra strobes show up here
	endtask

	task automatic apply_reset();
		reset          = 1'b1;
		sample_valid_i = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset      = 1'b0;
		batch_pos  = 0; // first batch counts from the next sample
		batch_cost = 0;
		batch_cnt  = 0;
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	// compare at the falling edge, away from the driving edge
	always @(negedge clk) begin : monitor
		sample_exp_t          e;
		eval_pkg::batch_res_t b;

		if (sample_done_o !== 1'b0) begin
			if (sample_exp_q.size() == 0) begin
				errors++;
				$display("sample_done_o strobed at cycle %0d with no sample in flight", cycle_cnt);
			end else begin
				e = sample_exp_q.pop_front();
				check_value("sample_done_o cycle", cycle_cnt, e.cycle);
				check_value("sample_res_o.cost", sample_res_o.cost, e.res.cost);
				check_value("sample_res_o.correct", sample_res_o.correct, e.res.correct);
				check_value("batch_done_o", batch_done_o, e.batch_end); // only on the 8th
			end
		end
		if (batch_done_o !== 1'b0) begin
			if (sample_done_o !== 1'b1) begin
				errors++;
				$display("batch_done_o strobed at cycle %0d without sample_done_o", cycle_cnt);
			end
			if (batch_exp_q.size() == 0) begin
				errors++;
				$display("batch_done_o strobed at cycle %0d before eight samples", cycle_cnt);
			end else begin
				b = batch_exp_q.pop_front();
				check_value("batch_res_o.cost", batch_res_o.cost, b.cost);
				check_value("batch_res_o.correct_cnt", batch_res_o.correct_cnt, b.correct_cnt);
			end
		end
	end

	initial begin : watchdog
		repeat (timeout_cycles) @(posedge clk);
		errors++;
		$display("watchdog expired after %0d cycles, results stopped arriving", timeout_cycles);
		finish_run();
	end

	initial begin
		reset          = 1'b1;
		sample_valid_i = 1'b0;
		sample_i       = '0;
		apply_reset();
		idle_cycles(6); // quiet after reset, no strobe allowed
		send_sample(uniform_sample('0, 0)); // all tie at zero, argmax 0, cost 1.0
		send_sample(uniform_sample(nn_fixed_pkg::fixed_min, 0)); // a-y clamps low
		send_sample(uniform_sample(nn_fixed_pkg::fixed_max, 3)); // sum pinned at max
		run_random(num_random_a);
		wait_drain();
		// second reset lands mid-batch, the partial batch must be dropped
		apply_reset();
		idle_cycles(6);
		run_random(num_random_b);
		wait_drain();
		if (batch_exp_q.size() != 0) begin
			errors++;
			$display("%0d expected batch results were never strobed", batch_exp_q.size());
		end
		finish_run();
	end

endmodule

// File: src/output_eval_top.sv
// no back-pressure; sample_done_o comes two cycles after sample_valid_i, batch_done_o every 8th
`timescale 1ns/1ns

module output_eval_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sample_valid_i,
	input  eval_pkg::sample_t     sample_i,
	output logic                  sample_done_o,
	output eval_pkg::sample_res_t sample_res_o,
	output logic                  batch_done_o,
	output eval_pkg::batch_res_t  batch_res_o
);

	logic                 cost_valid;
	nn_fixed_pkg::fixed_t cost;
	eval_pkg::class_t     pred;

	// cost path, needs the label for y
	cost_unit u_cost (
		.clk      (clk),
		.reset    (reset),
		.valid_i  (sample_valid_i),
		.sample_i (sample_i),
		.valid_o  (cost_valid),
		.cost_o   (cost)
	);

	// argmax path, activations only
	// its strobe is cycle-equal to cost_valid, the combiner keys on that one
	class_unit u_class (
		.clk     (clk),
		.reset   (reset),
		.valid_i (sample_valid_i),
		.acts_i  (sample_i.acts),
		.valid_o (),
		.pred_o  (pred)
	);

	eval_accum u_accum (
		.clk            (clk),
		.reset          (reset),
		.sample_valid_i (sample_valid_i),
		.label_i        (sample_i.label), // delayed inside to meet the unit results
		.cost_valid_i   (cost_valid),
		.cost_i         (cost),
		.pred_i         (pred),
		.sample_done_o  (sample_done_o),
		.sample_res_o   (sample_res_o),
		.batch_done_o   (batch_done_o),
		.batch_res_o    (batch_res_o)
	);

endmodule

// File: src/eval_accum.sv
// batch boundaries count from the first sample after reset; batch cost clamps at fixed_max
`timescale 1ns/1ns

module eval_accum (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sample_valid_i, // input strobe, used to capture the label
	input  eval_pkg::class_t       label_i,
	input  logic                   cost_valid_i, // unit results valid, one cycle later
	input  nn_fixed_pkg::fixed_t   cost_i,
	input  eval_pkg::class_t       pred_i,
	output logic                   sample_done_o,
	output eval_pkg::sample_res_t  sample_res_o,
	output logic                   batch_done_o,
	output eval_pkg::batch_res_t   batch_res_o
);

	eval_pkg::class_t label_q; // label lined up with the unit results
	logic             correct;

	// running batch state
	nn_fixed_pkg::fixed_t cost_sum_q;
	nn_fixed_pkg::fixed_t cost_sum_next; // includes the current sample
	eval_pkg::count_t     correct_cnt_q;
	eval_pkg::count_t     correct_cnt_next;
	eval_pkg::batch_pos_t batch_pos_q; // 0..batch_len-1
	logic                 batch_last; // current sample closes the batch

	// one stage delay, same as the units, so back-to-back samples stay aligned
	always_ff @(posedge clk) begin
		if (sample_valid_i) begin
			label_q <= label_i;
		end
	end

	assign correct          = (pred_i == label_q);
	assign cost_sum_next    = nn_fixed_pkg::sat_add(cost_sum_q, cost_i);
	assign correct_cnt_next = correct_cnt_q + eval_pkg::count_t'(correct);
	assign batch_last       = (batch_pos_q == eval_pkg::batch_pos_t'(eval_pkg::batch_len - 1));

	// strobes, position and accumulators
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sample_done_o <= 1'b0;
			batch_done_o  <= 1'b0;
			batch_pos_q   <= '0;
			cost_sum_q    <= '0;
			correct_cnt_q <= '0;
		end else begin
			sample_done_o <= cost_valid_i;
			batch_done_o  <= cost_valid_i & batch_last; // same cycle as the 8th sample_done
			if (cost_valid_i) begin
				if (batch_last) begin
					batch_pos_q   <= '0; // start the next batch empty
					cost_sum_q    <= '0;
					correct_cnt_q <= '0;
				end else begin
					batch_pos_q   <= batch_pos_q + 1'b1;
					cost_sum_q    <= cost_sum_next;
					correct_cnt_q <= correct_cnt_next;
				end
			end
		end
	end

	// result fields, hold between strobes
	always_ff @(posedge clk) begin
		if (cost_valid_i) begin
			sample_res_o.cost    <= cost_i;
			sample_res_o.correct <= correct;
			if (batch_last) begin
				batch_res_o.cost        <= cost_sum_next;
				batch_res_o.correct_cnt <= correct_cnt_next;
			end
		end
	end

endmodule

// File: src/class_unit.sv
// argmax over four activations, one cycle latency; signed compare, the lower index wins a tie
`timescale 1ns/1ns

module class_unit (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_i, // one-cycle strobe per sample
	input  eval_pkg::acts_t   acts_i,
	output logic              valid_o, // follows valid_i by one cycle
	output eval_pkg::class_t  pred_o // winning neuron, held between strobes
);

	localparam int num_pairs = eval_pkg::num_neurons / 2;

	nn_fixed_pkg::fixed_t act [eval_pkg::num_neurons]; // unpacked copy, signed per element

	// first level winners, one per pair
	nn_fixed_pkg::fixed_t pair_val [num_pairs];
	eval_pkg::class_t     pair_idx [num_pairs];

	eval_pkg::class_t win_idx; // second level result

	for (genvar i = 0; i < eval_pkg::num_neurons; i++) begin : g_unpack
		assign act[i] = acts_i[i];
	end

	// level 1: neighbours 2j and 2j+1, upper one only when strictly larger
	for (genvar j = 0; j < num_pairs; j++) begin : g_level1
		logic upper_wins;

		assign upper_wins  = act[2*j+1] > act[2*j];
		assign pair_val[j] = upper_wins ? act[2*j+1] : act[2*j];
		assign pair_idx[j] = upper_wins ? eval_pkg::class_t'(2*j+1) : eval_pkg::class_t'(2*j);
	end

	// level 2: pair 0 holds the lower indices, so it keeps ties
	assign win_idx = (pair_val[1] > pair_val[0]) ? pair_idx[1] : pair_idx[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			pred_o <= win_idx; // index only, the max value itself is not needed downstream
		end
	end

endmodule

// File: src/cost_unit.sv
// quadratic cost per sample, one cycle latency; label must be a valid neuron index, y is one-hot
`timescale 1ns/1ns

module cost_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_i, // one-cycle strobe per sample
	input  eval_pkg::sample_t    sample_i,
	output logic                 valid_o, // follows valid_i by one cycle
	output nn_fixed_pkg::fixed_t cost_o // held between strobes
);

	// a-y per neuron
	nn_fixed_pkg::fixed_t diff [eval_pkg::num_neurons];

	// (a-y)^2 per neuron, already rounded and clamped
	nn_fixed_pkg::fixed_t sq [eval_pkg::num_neurons];

	nn_fixed_pkg::fixed_t sum; // saturating sum of squares

	for (genvar i = 0; i < eval_pkg::num_neurons; i++) begin : g_neuron
		nn_fixed_pkg::fixed_t neg_y; // -y, i.e. -1.0 on the labelled neuron

		assign neg_y = (sample_i.label == eval_pkg::class_t'(i)) ?
			-nn_fixed_pkg::fixed_one : '0;

		// a + (-y), clamps when a is near fixed_min
		assign diff[i] = nn_fixed_pkg::sat_add(sample_i.acts[i], neg_y);

		// squaring, both inputs the same term
		fx_multiply u_square (
			.a_i (diff[i]),
			.b_i (diff[i]),
			.z_o (sq[i])
		);
	end

	// add in index order, clamp after every step
	always_comb begin
		sum = '0;
		for (int i = 0; i < eval_pkg::num_neurons; i++) begin
			sum = nn_fixed_pkg::sat_add(sum, sq[i]); // squares are >= 0, only top clamp hits
		end
	end

	// strobe
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// result word, loads only on a sample
	always_ff @(posedge clk) begin
		if (valid_i) begin
			cost_o <= sum;
		end
	end

endmodule

// File: src/fx_multiply.sv
// combinational 1.5.10 multiply; rounds half up toward +inf and clamps, so results never wrap
`timescale 1ns/1ns

module fx_multiply (
	input  nn_fixed_pkg::fixed_t a_i,
	input  nn_fixed_pkg::fixed_t b_i,
	output nn_fixed_pkg::fixed_t z_o
);

	// full product carries 2*frac_bits fraction bits
	logic signed [nn_fixed_pkg::prod_width-1:0] prod_full;

	// one extra bit so the rounding add cannot overflow
	logic signed [nn_fixed_pkg::prod_width:0] prod_rnd;

	// rounded product back at frac_bits, still wider than a word
	logic signed [nn_fixed_pkg::prod_width-nn_fixed_pkg::frac_bits:0] quot;

	assign prod_full = a_i * b_i; // both signed, sign extended to product width

	// add half an lsb, arithmetic shift below gives floor so this is round half up
	assign prod_rnd = prod_full + nn_fixed_pkg::round_half;

	// drop the low frac_bits
	assign quot = prod_rnd[nn_fixed_pkg::prod_width:nn_fixed_pkg::frac_bits];

	// clamp after rounding, so a value just under max can not round past it
	always_comb begin
		if (quot > nn_fixed_pkg::fixed_max) begin
			z_o = nn_fixed_pkg::fixed_max; // positive overflow
		end else if (quot < nn_fixed_pkg::fixed_min) begin
			z_o = nn_fixed_pkg::fixed_min; // negative overflow
		end else begin
			z_o = quot[nn_fixed_pkg::fixed_width-1:0]; // fits, take the low word
		end
	end

endmodule

// File: src/eval_pkg.sv
// sizes are fixed at four neurons and a batch of eight; index 0 sits in the lowest word of acts
package eval_pkg;

	localparam int num_neurons = 4; // output neurons per sample
	localparam int batch_len   = 8; // samples per batch

	// neuron index, two bits for four neurons
	typedef logic [$clog2(num_neurons)-1:0] class_t;

	// correct count, must hold 0..batch_len
	typedef logic [$clog2(batch_len+1)-1:0] count_t;

	// position of a sample inside its batch
	typedef logic [$clog2(batch_len)-1:0] batch_pos_t;

	// activation vector, element 0 in the low bits
	typedef nn_fixed_pkg::fixed_t [num_neurons-1:0] acts_t;

	// one input sample: activations then the class label
	typedef struct packed {
		acts_t  acts;
		class_t label;
	} sample_t;

	// per-sample result
	typedef struct packed {
		nn_fixed_pkg::fixed_t cost; // quadratic cost of the sample
		logic                 correct; // argmax matched the label
	} sample_res_t;

	// per-batch result
	typedef struct packed {
		nn_fixed_pkg::fixed_t cost; // saturated sum of sample costs
		count_t               correct_cnt; // correct predictions in the batch
	} batch_res_t;

endpackage

// File: src/nn_fixed_pkg.sv
// signed 1.5.10 two's complement only; the width is fixed here and every arithmetic block assumes it
package nn_fixed_pkg;

	// number format
	localparam int int_bits    = 5; // integer bits, sign not counted
	localparam int frac_bits   = 10; // fraction bits
	localparam int fixed_width = 1 + int_bits + frac_bits; // sign + int + frac = 16
	localparam int prod_width  = 2 * fixed_width; // full product of two words

	typedef logic signed [fixed_width-1:0] fixed_t;

	// saturation bounds
	localparam fixed_t fixed_max = {1'b0, {(fixed_width-1){1'b1}}}; // +31.999
	localparam fixed_t fixed_min = {1'b1, {(fixed_width-1){1'b0}}}; // -32.0
	localparam fixed_t fixed_one = fixed_t'(1 << frac_bits); // 1.0, target value for y

	// half an lsb of the result, added before the fraction bits are dropped
	localparam int round_half = 1 << (frac_bits - 1);

	// add with clamp to the range, no wrap
	function automatic fixed_t sat_add(input fixed_t a, input fixed_t b);
		logic signed [fixed_width:0] s; // one guard bit catches the overflow
		s = a + b;
		if (s > fixed_max) begin
			return fixed_max;
		end else if (s < fixed_min) begin
			return fixed_min;
		end
		return s[fixed_width-1:0];
	endfunction

endpackage
